/* rtl/decode_settings.svh */
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// RV32 major opcodes
`define RV32_LUI_OP      7'b0110111
`define RV32_AUIPC_OP    7'b0010111
`define RV32_JAL_OP      7'b1101111
`define RV32_JALR_OP     7'b1100111
`define RV32_BRANCH      7'b1100011
`define RV32_LOAD        7'b0000011
`define RV32_STORE       7'b0100011
`define RV32_OP_IMM      7'b0010011
`define RV32_OP          7'b0110011
`define RV32_AMO         7'b0101111
`define RV32_MISC_MEM    7'b0001111

// MISC-MEM funct3 codes
`define RV32_FENCE_FUN3    3'b000
`define RV32_FENCE_I_FUN3  3'b001

// Word-sized AMO funct3
`define RV32_AMO_W_FUN3    3'b010

// M extension funct7 under the OP opcode
`define RV32_MD_FUN7       7'b0000001

// AMOSWAP funct7 with the aq bit or the rl bit set
`define RV32_AMOSWAP_AQ_FUN7  7'b0000110
`define RV32_AMOSWAP_RL_FUN7  7'b0000101

// LR.W with any aq/rl bits, rs1 and rd; rs2 must be zero
`define RV32_LR_W  32'b00010_??_00000_?????_010_?????_0101111

// Bit position of the aq flag in an AMO word
`define RV32_AQ_BIT  26

// Memory operations allowed in flight at once
`define MEM_MAX_OUTSTANDING  4

`endif

/* rtl/decode_pkg.sv */
`default_nettype none

`include "decode_settings.svh"

package decode_pkg;

    // Full fetched instruction word
    typedef logic [31:0] instr_t;

    // Instruction fields
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;
    typedef logic [4:0] reg_idx_t;

    // Sign-extended immediate as handed to execute
    typedef logic [31:0] imm_t;

    // Must hold every value from zero up to the limit
    typedef logic [$clog2(`MEM_MAX_OUTSTANDING + 1) - 1:0] mem_cnt_t;

    // Memory-ordering controller states
    typedef enum logic [0:0] {
        ORD_IDLE,
        ORD_DRAIN
    } order_state_e;

endpackage

`default_nettype wire

/* rtl/cl_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_settings.svh"

module cl_decode (
    input  decode_pkg::instr_t instruction_i,
    input  logic               icache_miss_i,
    output logic               op_writes_rf_o,
    output logic               is_mem_op_o,
    output logic               is_byte_op_o,
    output logic               is_hex_op_o,
    output logic               is_load_op_o,
    output logic               is_load_unsigned_o,
    output logic               is_store_op_o,
    output logic               is_branch_op_o,
    output logic               is_jump_op_o,
    output logic               op_reads_rf1_o,
    output logic               op_reads_rf2_o,
    output logic               op_is_auipc_o,
    output logic               is_md_instr_o,
    output logic               op_is_load_reservation_o,
    output logic               op_is_lr_acq_o,
    output logic               is_fence_op_o,
    output logic               is_fence_i_op_o,
    output logic               op_is_swap_aq_o,
    output logic               op_is_swap_rl_o
);

    import decode_pkg::*;

    opcode_t  op;
    funct3_t  funct3;
    funct7_t  funct7;
    reg_idx_t rd;
    reg_idx_t rs1;
    logic     is_swap;

    assign op     = instruction_i[6:0];
    assign rd     = instruction_i[11:7];
    assign funct3 = instruction_i[14:12];
    assign rs1    = instruction_i[19:15];
    assign funct7 = instruction_i[31:25];

    // Only AMOSWAP.aq and AMOSWAP.rl are supported among the AMOs
    assign is_swap = (funct7 == `RV32_AMOSWAP_AQ_FUN7) | (funct7 == `RV32_AMOSWAP_RL_FUN7);

    // Register file write
    always_comb begin
        unique case (op)
            `RV32_LUI_OP, `RV32_AUIPC_OP, `RV32_JAL_OP, `RV32_JALR_OP,
            `RV32_LOAD, `RV32_OP, `RV32_OP_IMM, `RV32_AMO:
                op_writes_rf_o = 1'b1;
            default:
                op_writes_rf_o = 1'b0;
        endcase
    end

    // Data memory access; a fetch miss is replayed as a load
    always_comb begin
        unique case (op)
            `RV32_LOAD, `RV32_STORE, `RV32_AMO:
                is_mem_op_o = 1'b1;
            default:
                is_mem_op_o = icache_miss_i;
        endcase
    end

    // LB, LBU and SB
    always_comb begin
        unique case (funct3)
            3'b000, 3'b100:
                is_byte_op_o = icache_miss_i ? 1'b0 : is_mem_op_o;
            default:
                is_byte_op_o = 1'b0;
        endcase
    end

    // LH, LHU and SH
    always_comb begin
        unique case (funct3)
            3'b001, 3'b101:
                is_hex_op_o = icache_miss_i ? 1'b0 : is_mem_op_o;
            default:
                is_hex_op_o = 1'b0;
        endcase
    end

    // LR.W and AMOSWAP both return a value
    always_comb begin
        unique case (op)
            `RV32_LOAD, `RV32_AMO:
                is_load_op_o = 1'b1;
            default:
                is_load_op_o = icache_miss_i;
        endcase
    end

    assign is_load_unsigned_o = funct3[2] ? is_load_op_o : 1'b0;

    always_comb begin
        unique case (op)
            `RV32_STORE:
                is_store_op_o = 1'b1;
            `RV32_AMO:
                is_store_op_o = is_swap;
            default:
                is_store_op_o = 1'b0;
        endcase
    end

    assign is_branch_op_o = (op == `RV32_BRANCH);
    assign is_jump_op_o   = (op == `RV32_JAL_OP) | (op == `RV32_JALR_OP);

    // First register file read port
    always_comb begin
        unique case (op)
            `RV32_JALR_OP, `RV32_BRANCH, `RV32_LOAD, `RV32_STORE,
            `RV32_OP, `RV32_OP_IMM, `RV32_AMO:
                op_reads_rf1_o = 1'b1;
            default:
                op_reads_rf1_o = 1'b0;
        endcase
    end

    // Second read port; LR.W has no rs2 operand
    always_comb begin
        unique case (op)
            `RV32_BRANCH, `RV32_STORE, `RV32_OP:
                op_reads_rf2_o = 1'b1;
            `RV32_AMO:
                op_reads_rf2_o = is_swap;
            default:
                op_reads_rf2_o = 1'b0;
        endcase
    end

    assign op_is_auipc_o = (op == `RV32_AUIPC_OP);

    // M extension shares the OP opcode
    assign is_md_instr_o = (op == `RV32_OP) & (funct7 == `RV32_MD_FUN7);

    // Memory ordering instructions
    assign op_is_load_reservation_o = (instruction_i ==? `RV32_LR_W);
    assign op_is_lr_acq_o = op_is_load_reservation_o & instruction_i[`RV32_AQ_BIT];

    assign is_fence_op_o = (op == `RV32_MISC_MEM)
                         & (funct3 == `RV32_FENCE_FUN3)
                         & (rs1 == 5'd0)
                         & (rd == 5'd0)
                         & (instruction_i[31:28] == 4'd0);

    // FENCE.I has an all-zero immediate field
    assign is_fence_i_op_o = (op == `RV32_MISC_MEM)
                           & (funct3 == `RV32_FENCE_I_FUN3)
                           & (rs1 == 5'd0)
                           & (rd == 5'd0)
                           & (instruction_i[31:20] == 12'd0);

    assign op_is_swap_aq_o = (op == `RV32_AMO)
                           & (funct3 == `RV32_AMO_W_FUN3)
                           & (funct7 == `RV32_AMOSWAP_AQ_FUN7);

    assign op_is_swap_rl_o = (op == `RV32_AMO)
                           & (funct3 == `RV32_AMO_W_FUN3)
                           & (funct7 == `RV32_AMOSWAP_RL_FUN7);

endmodule

`default_nettype wire

/* rtl/imm_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_settings.svh"

module imm_gen (
    input  decode_pkg::instr_t instruction_i,
    output decode_pkg::imm_t   imm_o
);

    import decode_pkg::*;

    opcode_t op;
    logic    sign;

    assign op   = instruction_i[6:0];
    assign sign = instruction_i[31];

    always_comb begin
        unique case (op)
            // I format
            `RV32_LOAD, `RV32_OP_IMM, `RV32_JALR_OP:
                imm_o = {{20{sign}}, instruction_i[31:20]};
            // S format
            `RV32_STORE:
                imm_o = {{20{sign}}, instruction_i[31:25], instruction_i[11:7]};
            // B format, always an even offset
            `RV32_BRANCH:
                imm_o = {{19{sign}}, sign, instruction_i[7], instruction_i[30:25],
                         instruction_i[11:8], 1'b0};
            // U format fills the upper 20 bits
            `RV32_LUI_OP, `RV32_AUIPC_OP:
                imm_o = {instruction_i[31:12], 12'd0};
            // J format
            `RV32_JAL_OP:
                imm_o = {{11{sign}}, sign, instruction_i[19:12], instruction_i[20],
                         instruction_i[30:21], 1'b0};
            default:
                imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/mem_order_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_settings.svh"

module mem_order_ctrl (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic id_valid_i,
    input  logic is_mem_op_i,
    input  logic is_fence_op_i,
    input  logic op_is_lr_acq_i,
    input  logic op_is_swap_aq_i,
    input  logic mem_done_i,
    output logic stall_o
);

    import decode_pkg::*;

    localparam mem_cnt_t cnt_max = mem_cnt_t'(`MEM_MAX_OUTSTANDING);

    mem_cnt_t     mem_cnt;
    order_state_e state;
    logic         order_req;
    logic         cnt_zero;
    logic         cnt_inc;
    logic         cnt_dec;

    // Instructions that must wait for older memory ops to drain
    assign order_req = id_valid_i & (is_fence_op_i | op_is_lr_acq_i | op_is_swap_aq_i);
    assign cnt_zero  = (mem_cnt == '0);

    assign stall_o = (order_req & ~cnt_zero)
                   | (id_valid_i & is_mem_op_i & (mem_cnt == cnt_max));

    // An op counts once it leaves ID
    assign cnt_inc = id_valid_i & ~stall_o & is_mem_op_i;
    assign cnt_dec = mem_done_i & ~cnt_zero;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mem_cnt <= '0;
        end else if (cnt_inc && !cnt_dec) begin
            mem_cnt <= mem_cnt + mem_cnt_t'(1);
        end else if (cnt_dec && !cnt_inc) begin
            mem_cnt <= mem_cnt - mem_cnt_t'(1);
        end
    end

    // Drain tracking; the held instruction issues once the count is zero
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state <= ORD_IDLE;
        end else begin
            unique case (state)
                ORD_IDLE:
                    if (order_req && !cnt_zero) begin
                        state <= ORD_DRAIN;
                    end
                ORD_DRAIN:
                    if (cnt_zero) begin
                        state <= ORD_IDLE;
                    end
                default:
                    state <= ORD_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 instr_valid_i,
    input  decode_pkg::instr_t   instr_i,
    input  logic                 icache_miss_i,
    input  logic                 mem_done_i,
    output logic                 id_valid_o,
    output logic                 stall_o,
    output logic                 op_writes_rf_o,
    output logic                 is_mem_op_o,
    output logic                 is_byte_op_o,
    output logic                 is_hex_op_o,
    output logic                 is_load_op_o,
    output logic                 is_load_unsigned_o,
    output logic                 is_store_op_o,
    output logic                 is_branch_op_o,
    output logic                 is_jump_op_o,
    output logic                 op_reads_rf1_o,
    output logic                 op_reads_rf2_o,
    output logic                 op_is_auipc_o,
    output logic                 is_md_instr_o,
    output logic                 op_is_load_reservation_o,
    output logic                 op_is_lr_acq_o,
    output logic                 is_fence_op_o,
    output logic                 is_fence_i_op_o,
    output logic                 op_is_swap_aq_o,
    output logic                 op_is_swap_rl_o,
    output decode_pkg::imm_t     imm_o,
    output decode_pkg::reg_idx_t rd_o,
    output decode_pkg::reg_idx_t rs1_o,
    output decode_pkg::reg_idx_t rs2_o
);

    import decode_pkg::*;

    logic   id_valid_q;
    instr_t instr_q;
    logic   icache_miss_q;

    // IF/ID register, frozen while the stage stalls
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            id_valid_q <= 1'b0;
        end else if (!stall_o) begin
            id_valid_q <= instr_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_o) begin
            instr_q       <= instr_i;
            icache_miss_q <= icache_miss_i;
        end
    end

    assign id_valid_o = id_valid_q;

    // Register indices straight from the held word
    assign rd_o  = instr_q[11:7];
    assign rs1_o = instr_q[19:15];
    assign rs2_o = instr_q[24:20];

    cl_decode u_cl_decode (
        .instruction_i            (instr_q),
        .icache_miss_i            (icache_miss_q),
        .op_writes_rf_o           (op_writes_rf_o),
        .is_mem_op_o              (is_mem_op_o),
        .is_byte_op_o             (is_byte_op_o),
        .is_hex_op_o              (is_hex_op_o),
        .is_load_op_o             (is_load_op_o),
        .is_load_unsigned_o       (is_load_unsigned_o),
        .is_store_op_o            (is_store_op_o),
        .is_branch_op_o           (is_branch_op_o),
        .is_jump_op_o             (is_jump_op_o),
        .op_reads_rf1_o           (op_reads_rf1_o),
        .op_reads_rf2_o           (op_reads_rf2_o),
        .op_is_auipc_o            (op_is_auipc_o),
        .is_md_instr_o            (is_md_instr_o),
        .op_is_load_reservation_o (op_is_load_reservation_o),
        .op_is_lr_acq_o           (op_is_lr_acq_o),
        .is_fence_op_o            (is_fence_op_o),
        .is_fence_i_op_o          (is_fence_i_op_o),
        .op_is_swap_aq_o          (op_is_swap_aq_o),
        .op_is_swap_rl_o          (op_is_swap_rl_o)
    );

    imm_gen u_imm_gen (
        .instruction_i (instr_q),
        .imm_o         (imm_o)
    );

    mem_order_ctrl u_mem_order_ctrl (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .id_valid_i      (id_valid_q),
        .is_mem_op_i     (is_mem_op_o),
        .is_fence_op_i   (is_fence_op_o),
        .op_is_lr_acq_i  (op_is_lr_acq_o),
        .op_is_swap_aq_i (op_is_swap_aq_o),
        .mem_done_i      (mem_done_i),
        .stall_o         (stall_o)
    );

endmodule

`default_nettype wire

/* sim/decode_stage_properties.sv */
`timescale 1ns/1ps
`include "decode_settings.svh"
`default_nettype none

module decode_stage_properties (
    input logic                 clk_i,
    input logic                 rst_n_i,
    input logic                 id_valid_i,
    input logic                 stall_i,
    input decode_pkg::mem_cnt_t mem_cnt_i
);

    import decode_pkg::*;

    // An empty ID stage cannot stall right out of reset
    stall_low_after_reset: assert property (
        @(posedge clk_i) !rst_n_i |=> !stall_i
    ) else $error("stall_o high in the cycle after reset");

    cnt_within_limit: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        mem_cnt_i <= `MEM_MAX_OUTSTANDING
    ) else $error("outstanding count above its limit");

    no_stall_when_invalid: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !id_valid_i |-> !stall_i
    ) else $error("stall_o high with no valid ID entry");

endmodule

bind mem_order_ctrl decode_stage_properties u_properties (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .id_valid_i (id_valid_i),
    .stall_i    (stall_o),
    .mem_cnt_i  (mem_cnt)
);

`default_nettype wire

/* sim/decode_stage_tb.sv */
`timescale 1ns/1ps
`include "decode_settings.svh"
`default_nettype none

module decode_stage_tb;

    import decode_pkg::*;

    localparam int          max_vectors = 64;
    localparam logic [31:0] lfsr_seed   = 32'h2843a27b;
    localparam logic [31:0] lfsr_taps   = 32'h80200003;

    // Bit positions in the expected control mask
    localparam int m_mem     = 17;
    localparam int m_lr_acq  = 4;
    localparam int m_fence   = 3;
    localparam int m_swap_aq = 1;

    logic     clk_i;
    logic     rst_n_i;
    logic     instr_valid_i;
    instr_t   instr_i;
    logic     icache_miss_i;
    logic     mem_done_i;
    logic     id_valid_o;
    logic     stall_o;
    logic     op_writes_rf_o;
    logic     is_mem_op_o;
    logic     is_byte_op_o;
    logic     is_hex_op_o;
    logic     is_load_op_o;
    logic     is_load_unsigned_o;
    logic     is_store_op_o;
    logic     is_branch_op_o;
    logic     is_jump_op_o;
    logic     op_reads_rf1_o;
    logic     op_reads_rf2_o;
    logic     op_is_auipc_o;
    logic     is_md_instr_o;
    logic     op_is_load_reservation_o;
    logic     op_is_lr_acq_o;
    logic     is_fence_op_o;
    logic     is_fence_i_op_o;
    logic     op_is_swap_aq_o;
    logic     op_is_swap_rl_o;
    imm_t     imm_o;
    reg_idx_t rd_o;
    reg_idx_t rs1_o;
    reg_idx_t rs2_o;

    // Entry 0 holds the vector count; fields are word, miss, mask, imm
    logic [87:0] vec_mem [0:max_vectors];
    int          num_vectors;
    int          run_q[$];

    // Model of the ID entry and the outstanding count
    logic        model_valid;
    logic [31:0] model_word;
    logic [19:0] model_mask;
    logic [31:0] model_imm;
    int          model_cnt;
    logic [19:0] pres_mask;
    logic [31:0] pres_imm;

    logic [31:0] lfsr_state;
    int          cycle_cnt;
    int          cycle_limit = 4 * max_vectors + 200;
    logic        full_seen;
    logic        drain_seen;
    logic [19:0] dut_mask;

    assign dut_mask = {1'b0, op_writes_rf_o, is_mem_op_o, is_byte_op_o, is_hex_op_o,
                       is_load_op_o, is_load_unsigned_o, is_store_op_o, is_branch_op_o,
                       is_jump_op_o, op_reads_rf1_o, op_reads_rf2_o, op_is_auipc_o,
                       is_md_instr_o, op_is_load_reservation_o, op_is_lr_acq_o,
                       is_fence_op_o, is_fence_i_op_o, op_is_swap_aq_o, op_is_swap_rl_o};

    decode_stage uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            lfsr_next = (s >> 1) ^ lfsr_taps;
        end else begin
            lfsr_next = s >> 1;
        end
    endfunction

    function automatic logic is_ordering(input logic [19:0] mask);
        is_ordering = mask[m_fence] | mask[m_lr_acq] | mask[m_swap_aq];
    endfunction

    // Stall rule applied to the modelled ID entry
    function automatic logic model_stall();
        model_stall = model_valid
                    && ((is_ordering(model_mask) && model_cnt != 0)
                    || (model_mask[m_mem] && model_cnt == `MEM_MAX_OUTSTANDING));
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "%s", reason);
    endtask

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("** FAIL **");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_outputs();
        compare_value("id_valid_o", 32'(id_valid_o), 32'(model_valid));
        compare_value("stall_o", 32'(stall_o), 32'(model_stall()));
        if (model_valid) begin
            compare_value("decode_mask", 32'(dut_mask), 32'(model_mask));
            compare_value("imm_o", imm_o, model_imm);
            compare_value("rd_o", 32'(rd_o), 32'(model_word[11:7]));
            compare_value("rs1_o", 32'(rs1_o), 32'(model_word[19:15]));
            compare_value("rs2_o", 32'(rs2_o), 32'(model_word[24:20]));
        end
    endtask

    task automatic present(input int idx);
        if (idx > 0) begin
            instr_valid_i = 1'b1;
            instr_i       = vec_mem[idx][87:56];
            icache_miss_i = vec_mem[idx][52];
            pres_mask     = vec_mem[idx][51:32];
            pres_imm      = vec_mem[idx][31:0];
        end else begin
            instr_valid_i = 1'b0;
            icache_miss_i = 1'b0;
            pres_mask     = '0;
            pres_imm      = '0;
        end
    endtask

    // Completions only while something is outstanding
    task automatic drive_done(input logic random_done);
        if (model_cnt == 0) begin
            mem_done_i = 1'b0;
        end else if (random_done) begin
            lfsr_state = lfsr_next(lfsr_state);
            mem_done_i = lfsr_state[0];
        end else begin
            mem_done_i = (model_cnt == `MEM_MAX_OUTSTANDING);
        end
    endtask

    // Called 1 ns after a rising edge; returns at the same point
    task automatic run_queue(input logic random_done);
        int   pos;
        logic stall_exp;
        pos = 0;
        present(run_q[0]);
        drive_done(random_done);
        while (pos < run_q.size() || model_valid) begin
            @(negedge clk_i);
            check_outputs();
            stall_exp = model_stall();
            if (stall_exp && model_mask[m_mem] && model_cnt == `MEM_MAX_OUTSTANDING) begin
                full_seen = 1'b1;
            end
            if (stall_exp && is_ordering(model_mask)) begin
                drain_seen = 1'b1;
            end
            @(posedge clk_i);
            if (model_valid && !stall_exp && model_mask[m_mem]) begin
                model_cnt++;
            end
            if (mem_done_i) begin
                model_cnt--;
            end
            if (!stall_exp) begin
                model_valid = instr_valid_i;
                model_word  = instr_i;
                model_mask  = pres_mask;
                model_imm   = pres_imm;
                if (instr_valid_i) begin
                    pos++;
                end
            end
            #1;
            if (!stall_exp) begin
                present(pos < run_q.size() ? run_q[pos] : 0);
            end
            drive_done(random_done);
        end
    endtask

    initial begin
        cycle_cnt = 0;
        forever begin
            @(posedge clk_i);
            cycle_cnt++;
            if (cycle_cnt > cycle_limit) begin
                abort_run("Timeout: the run did not finish within the cycle limit");
            end
        end
    end

    initial begin
        int k;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        icache_miss_i = 1'b0;
        mem_done_i    = 1'b0;
        model_valid   = 1'b0;
        model_word    = '0;
        model_mask    = '0;
        model_imm     = '0;
        model_cnt     = 0;
        pres_mask     = '0;
        pres_imm      = '0;
        lfsr_state    = lfsr_seed;
        full_seen     = 1'b0;
        drain_seen    = 1'b0;
        $readmemh("sim/decode_vectors.txt", vec_mem);
        num_vectors = int'(vec_mem[0][31:0]);
        if (num_vectors < 1 || num_vectors > max_vectors) begin
            abort_run("The vector file holds no usable vector count");
        end
        cycle_limit = 4 * num_vectors + 200;

        repeat (8) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        // Every vector in file order with random completions
        for (int i = 1; i <= num_vectors; i++) begin
            run_q.push_back(i);
        end
        run_queue(1'b1);

        // Back-to-back memory ops with completions held off until full
        run_q.delete();
        for (int i = 1; i <= num_vectors; i++) begin
            if (vec_mem[i][32 + m_mem] && !is_ordering(vec_mem[i][51:32])) begin
                run_q.push_back(i);
            end
        end
        if (run_q.size() == 0) begin
            abort_run("The vector file holds no plain memory operation");
        end
        k = 0;
        while (run_q.size() < 8) begin
            run_q.push_back(run_q[k]);
            k++;
        end
        run_queue(1'b0);
        if (!full_seen) begin
            abort_run("The outstanding count never reached its limit");
        end

        // Ordering instructions behind the memory ops still in flight
        run_q.delete();
        for (int i = 1; i <= num_vectors; i++) begin
            if (is_ordering(vec_mem[i][51:32])) begin
                run_q.push_back(i);
            end
        end
        if (run_q.size() == 0) begin
            abort_run("The vector file holds no ordering instruction");
        end
        run_queue(1'b1);
        if (!drain_seen) begin
            abort_run("No ordering instruction ever waited for a drain");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* sim/decode_vectors.txt */
// Columns: instruction word, cache-miss flag, expected control mask, expected immediate
// Mask bit 18 is op_writes_rf down to bit 0 op_is_swap_rl; the first entry is the count
00000000_0_00000_0000001C
123450B7_0_40000_12345000
FFFFF117_0_40080_FFFFF000
008000EF_0_40400_00000008
FF9FF0EF_0_40400_FFFFFFF8
00008067_0_40600_00000000
00208863_0_00B00_00000010
FE419EE3_0_00B00_FFFFFFFC
FFF30283_0_74200_FFFFFFFF
00445383_0_6E200_00000004
00854483_0_76200_00000008
00C12583_0_64200_0000000C
00312A23_0_21300_00000014
FE428F23_0_31300_FFFFFFFE
FFB00093_0_40200_FFFFFFFB
002081B3_0_40300_00000000
022081B3_0_40340_00000000
0220D1B3_0_40340_00000000
1003252F_0_64220_00000000
1403252F_0_64230_00000000
0C84A3AF_0_65302_00000000
0A84A3AF_0_65301_00000000
0FF0000F_0_00008_00000000
0000100F_0_00004_00000000
0000108F_0_00000_00000000
0010100F_0_00000_00000000
0FF0800F_0_00000_00000000
00100093_1_64200_00000001
FFF30283_1_64200_FFFFFFFF

/* build.f */
+incdir+rtl
rtl/decode_pkg.sv
rtl/cl_decode.sv
rtl/imm_gen.sv
rtl/mem_order_ctrl.sv
rtl/decode_stage.sv
sim/decode_stage_properties.sv
sim/decode_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the decode stage testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module decode_stage_tb -o decode_sim

# The simulator exits nonzero on a failed check; the log decides the result
./obj_dir/decode_sim > sim.log 2>&1 || true

if grep -F -q "** PASS **" sim.log; then
    echo "Simulation passed, see sim.log"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
